// File: dv/am_lock_lane_tb.sv
/*
 * alignment marker lock lane testbench
 * directed tests for lock, bip errors, lock loss, compare mask and block sync loss
 */
`default_nettype none

`include "am_lock_defines.svh"

module am_lock_lane_tb
    import am_lock_pkg::*;
();

    localparam int period = 8;
    localparam am_t lane_values [`AM_N_LANES] = '{
        `AM_LANE0_VALUE, `AM_LANE1_VALUE, `AM_LANE2_VALUE, `AM_LANE3_VALUE
    };

    logic        clock;
    logic        reset;
    logic        enable;
    logic        valid;
    logic        block_lock;
    block_t      data_in;
    am_t         compare_mask;
    period_t     am_period;
    thr_t        valid_thr;
    thr_t        invalid_thr;
    block_t      data_out;
    logic        valid_out;
    logic        start_of_lane;
    logic        am_lock;
    lane_id_t    lane_id;
    err_cnt_t    error_count;
    resync_cnt_t resync_count;

    int   errors;
    int   checks;
    int   tests_run;
    int   seed_value;
    logic timed_out;
    bip_t bip_model;       // parity since the last marker sent

    am_lock_lane DUT
    (
        .i_clock(clock), .i_reset(reset), .i_enable(enable), .i_valid(valid),
        .i_block_lock(block_lock), .i_data(data_in), .i_compare_mask(compare_mask),
        .i_am_period(am_period), .i_valid_thr(valid_thr), .i_invalid_thr(invalid_thr),
        .o_data(data_out), .o_valid(valid_out), .o_start_of_lane(start_of_lane),
        .o_am_lock(am_lock), .o_lane_id(lane_id), .o_error_count(error_count),
        .o_resync_count(resync_count)
    );

    always #5 clock = ~clock;

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond) else
        begin
            $display("ERR @%0t: %s", $time, msg);
            errors++;
        end
    endtask

    // bits with equal index mod 8 share a column across the payload bytes
    function automatic bip_t payload_bip(input block_t blk);
        bip_t parity;
        parity = '0;
        for (int b = 0; b < 8; b++)
            parity ^= blk[b*8 +: 8];
        return parity;
    endfunction

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        bip_model = '0;
    endtask

    // one valid block, then wait for it on the output
    task automatic drive_block(input block_t blk, input logic is_marker);
        int waited;
        @(posedge clock);
        data_in <= blk;
        valid   <= 1'b1;
        @(posedge clock);
        valid   <= 1'b0;
        waited = 0;
        @(negedge clock);
        while (!valid_out && waited < 4)
        begin
            @(negedge clock);
            waited++;
        end
        if (!valid_out)
        begin
            $display("timeout at %0t: output valid never came for an input block", $time);
            timed_out = 1'b1;
        end
        expect_true(waited == 0, "output block not one cycle after input");
        if (is_marker)
            bip_model = '0;
        else
            bip_model ^= payload_bip(blk);
    endtask

    task automatic stream_payload(input int count);
        block_t blk;
        for (int i = 0; i < count; i++)
        begin
            blk = {2'b01, $urandom, $urandom};      // data header
            drive_block(blk, 1'b0);
            expect_true(data_out == blk, $sformatf("payload changed, got %h", data_out));
            expect_true(!start_of_lane, "start of lane on a payload block");
        end
    endtask

    task automatic send_marker(input int lane, input am_t flip, input bip_t bip_flip,
                               input logic exp_replace, input logic exp_lock);
        am_t    am;
        block_t blk;
        block_t expected;
        am = lane_values[lane] ^ flip;
        blk = {2'b10, am[47:24], bip_model ^ bip_flip, am[23:0], 8'h00};
        expected = exp_replace ? {2'b10, `AM_CTRL_REPLACE} : blk;
        drive_block(blk, 1'b1);
        expect_true(data_out == expected, $sformatf("marker output %h", data_out));
        expect_true(start_of_lane == exp_replace, "start of lane flag wrong on marker");
        expect_true(am_lock == exp_lock, "lock state wrong after marker");
    endtask

    // third matching marker reaches lock with valid threshold 3
    task automatic lock_on_lane(input int lane, input am_t flip);
        for (int m = 0; m < 3; m++)
        begin
            send_marker(lane, flip, '0, m == 2, m == 2);
            stream_payload(period);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        $display("%-20s %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    task automatic reset_state_test();
        int e0;
        e0 = errors;
        expect_true(!am_lock && !valid_out && !start_of_lane, "flags not clear after reset");
        expect_true(error_count == '0 && resync_count == '0, "counts not zero after reset");
        expect_true(lane_id == '0, "lane id not zero after reset");
        report_test("reset state", e0);
    endtask

    task automatic lock_lane2_test();
        int e0;
        e0 = errors;
        lock_on_lane(2, '0);
        expect_true(lane_id == lane_id_t'(2), "lane id is not 2");
        report_test("lock on lane 2", e0);
    endtask

    task automatic bip_error_test();
        int e0;
        e0 = errors;
        send_marker(2, '0, 8'h01, 1'b1, 1'b1);
        stream_payload(period);
        send_marker(2, '0, 8'h80, 1'b1, 1'b1);
        stream_payload(period);
        send_marker(2, '0, '0, 1'b1, 1'b1);         // clean parity adds nothing
        stream_payload(period);
        expect_true(error_count == err_cnt_t'(2), "bip error count is not 2");
        report_test("bip errors", e0);
    endtask

    task automatic lock_loss_test();
        int          e0;
        resync_cnt_t start_count;
        e0 = errors;
        start_count = resync_count;
        send_marker(0, '0, '0, 1'b0, 1'b1);         // wrong lane while locked
        stream_payload(period);
        send_marker(0, '0, '0, 1'b0, 1'b0);
        expect_true(resync_count == resync_cnt_t'(start_count + 1), "resync count not +1");
        expect_true(error_count == '0, "bip error count not cleared on resync");
        report_test("lock loss", e0);
    endtask

    task automatic compare_mask_test();
        int e0;
        e0 = errors;
        apply_reset();
        @(posedge clock);
        compare_mask <= 48'h00FF00_0000FF;
        lock_on_lane(1, 48'h00A500_00005A);
        expect_true(lane_id == lane_id_t'(1), "lane id is not 1 with mask");
        @(posedge clock);
        compare_mask <= '0;
        apply_reset();
        for (int m = 0; m < 4; m++)
        begin
            send_marker(1, 48'h00A500_00005A, '0, 1'b0, 1'b0);
            stream_payload(period);
        end
        report_test("compare mask", e0);
    endtask

    task automatic block_lock_drop_test();
        int          e0;
        int          waited;
        resync_cnt_t start_count;
        e0 = errors;
        lock_on_lane(3, '0);
        start_count = resync_count;
        @(posedge clock);
        block_lock <= 1'b0;
        @(posedge clock);
        block_lock <= 1'b1;
        waited = 0;
        @(negedge clock);
        while (am_lock && waited < 4)
        begin
            @(negedge clock);
            waited++;
        end
        if (am_lock)
        begin
            $display("timeout at %0t: lock held after block sync was lost", $time);
            timed_out = 1'b1;
        end
        expect_true(resync_count == resync_cnt_t'(start_count + 1), "resync count not +1");
        report_test("block lock drop", e0);
    endtask

    initial
    begin
        clock = 1'b0;
        reset <= 1'b1;
        enable <= 1'b1;
        valid <= 1'b0;
        block_lock <= 1'b1;
        data_in <= '0;
        compare_mask <= '0;
        am_period <= period_t'(period);
        valid_thr <= thr_t'(3);
        invalid_thr <= thr_t'(2);
        errors = 0;
        checks = 0;
        tests_run = 0;
        timed_out = 1'b0;
        seed_value = $urandom(75091);
        apply_reset();
        reset_state_test();
        if (!timed_out) lock_lane2_test();
        if (!timed_out) bip_error_test();
        if (!timed_out) lock_loss_test();
        if (!timed_out) compare_mask_test();
        if (!timed_out) block_lock_drop_test();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
source/am_lock_pkg.sv
source/am_comparator.sv
source/am_lock_fsm.sv
source/bip_calculator.sv
source/bip_error_counter.sv
source/am_lock_lane.sv
dv/am_lock_lane_tb.sv

// File: include/am_lock_defines.svh
/*
 * alignment marker lock constants
 * widths, lane count, marker values and marker field positions
 */
`ifndef AM_LOCK_DEFINES_SVH
`define AM_LOCK_DEFINES_SVH

`define AM_NB_BLOCK         66
`define AM_NB_AM            48      // marker without bip
`define AM_NB_BIP           8
`define AM_N_LANES          4
`define AM_NB_LANE_ID       2
`define AM_NB_PERIOD        14
`define AM_NB_THR           4
`define AM_NB_ERR_CNT       16
`define AM_NB_RESYNC_CNT    8

// per lane marker as {m0, m1, m2, m4, m5, m6}
`define AM_LANE0_VALUE      48'hC16821_3E97DE
`define AM_LANE1_VALUE      48'h9D718E_628E71
`define AM_LANE2_VALUE      48'h594BE8_A6B417
`define AM_LANE3_VALUE      48'h4D957B_B26A84

`define AM_SH_CTRL          2'b10
`define AM_CTRL_REPLACE     64'h1E00_0000_0000_0000   // control block, all idle

`define AM_HI_MSB           63      // marker bits 47:24
`define AM_BIP_MSB          39
`define AM_LO_MSB           31      // marker bits 23:0

`endif

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --assert -f filelist.f --top-module am_lock_lane_tb -o am_lock_lane_sim
./obj_dir/am_lock_lane_sim | tee sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: source/am_comparator.sv
/*
 * alignment marker comparator
 * masked match of one marker field against the lane markers
 */
`default_nettype none

`include "am_lock_defines.svh"

module am_comparator
    import am_lock_pkg::*;
(
    input  am_t         i_am_value,
    input  am_t         i_compare_mask,     // set bits are ignored
    input  logic        i_restrict,
    input  lane_id_t    i_locked_lane,
    output logic        o_am_match,
    output lane_id_t    o_match_lane
);

    localparam am_t lane_values [`AM_N_LANES] = '{
        `AM_LANE0_VALUE,
        `AM_LANE1_VALUE,
        `AM_LANE2_VALUE,
        `AM_LANE3_VALUE
    };

    logic [`AM_N_LANES-1:0] lane_hit;

    for (genvar g = 0; g < `AM_N_LANES; g++)
    begin : g_lane
        logic pattern_ok;
        logic lane_allowed;

        assign pattern_ok   = (((i_am_value ^ lane_values[g]) & ~i_compare_mask) == '0);
        assign lane_allowed = !i_restrict || (i_locked_lane == lane_id_t'(g));
        assign lane_hit[g]  = pattern_ok && lane_allowed;
    end

    // priority encode, lowest lane wins
    always_comb
    begin
        o_am_match   = 1'b0;
        o_match_lane = '0;
        for (int lane = `AM_N_LANES - 1; lane >= 0; lane--)
        begin
            if (lane_hit[lane])
            begin
                o_am_match   = 1'b1;
                o_match_lane = lane_id_t'(lane);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/am_lock_fsm.sv
/*
 * alignment marker lock state machine
 * search, confirm and lock with marker spacing timer and threshold counters
 */
`default_nettype none

`include "am_lock_defines.svh"

module am_lock_fsm
    import am_lock_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_enable,
    input  logic        i_valid,
    input  logic        i_block_lock,
    input  logic        i_am_match,
    input  lane_id_t    i_match_lane,
    input  period_t     i_am_period,
    input  thr_t        i_valid_thr,
    input  thr_t        i_invalid_thr,
    output logic        o_restrict,
    output lane_id_t    o_locked_lane,
    output logic        o_am_lock,          // lock state after this block
    output logic        o_marker_accept,
    output logic        o_resync
);

    lock_state_t state;
    lock_state_t state_next;
    lane_id_t    locked_lane;
    lane_id_t    locked_lane_next;
    period_t     timer;
    period_t     timer_next;
    thr_t        valid_cnt;
    thr_t        valid_cnt_next;
    thr_t        invalid_cnt;
    thr_t        invalid_cnt_next;
    logic        accept;
    logic        resync;
    logic        step;
    logic        at_expected;
    logic [`AM_NB_THR:0] valid_inc;    // one extra bit against overflow
    logic [`AM_NB_THR:0] invalid_inc;

    assign step        = i_enable && i_valid;
    assign at_expected = (timer == i_am_period);   // marker slot
    assign valid_inc   = {1'b0, valid_cnt} + 1'b1;
    assign invalid_inc = {1'b0, invalid_cnt} + 1'b1;

    always_comb
    begin
        state_next       = state;
        locked_lane_next = locked_lane;
        timer_next       = timer;
        valid_cnt_next   = valid_cnt;
        invalid_cnt_next = invalid_cnt;
        accept           = 1'b0;
        resync           = 1'b0;

        if (i_enable && !i_block_lock)
        begin
            state_next = lock_search;       // block sync lost
            resync     = (state == lock_locked);
        end
        else if (step)
        begin
            case (state)
                lock_search:
                begin
                    if (i_am_match)
                    begin
                        state_next       = lock_confirm;
                        locked_lane_next = i_match_lane;
                        timer_next       = '0;
                        valid_cnt_next   = thr_t'(1);
                    end
                end
                lock_confirm:
                begin
                    if (!at_expected)
                        timer_next = timer + 1'b1;
                    else if (i_am_match)
                    begin
                        accept         = 1'b1;
                        timer_next     = '0;
                        valid_cnt_next = valid_inc[`AM_NB_THR-1:0];
                        if (valid_inc >= {1'b0, i_valid_thr})
                        begin
                            state_next       = lock_locked;
                            invalid_cnt_next = '0;
                        end
                    end
                    else
                        state_next = lock_search;
                end
                lock_locked:
                begin
                    if (!at_expected)
                        timer_next = timer + 1'b1;
                    else
                    begin
                        timer_next = '0;    // restart spacing even on a missed marker
                        if (i_am_match)
                        begin
                            accept           = 1'b1;
                            invalid_cnt_next = '0;
                        end
                        else if (invalid_inc >= {1'b0, i_invalid_thr})
                        begin
                            state_next = lock_search;
                            resync     = 1'b1;
                        end
                        else
                            invalid_cnt_next = invalid_inc[`AM_NB_THR-1:0];
                    end
                end
                default:
                    state_next = lock_search;
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state       <= lock_search;
            locked_lane <= '0;
            timer       <= '0;
            valid_cnt   <= '0;
            invalid_cnt <= '0;
        end
        else
        begin
            state       <= state_next;
            locked_lane <= locked_lane_next;
            timer       <= timer_next;
            valid_cnt   <= valid_cnt_next;
            invalid_cnt <= invalid_cnt_next;
        end
    end

    assign o_restrict      = (state != lock_search);    // only the recorded lane matches
    assign o_locked_lane   = locked_lane;
    assign o_am_lock       = (state_next == lock_locked);
    assign o_marker_accept = accept;
    assign o_resync        = resync;

    // a block sync loss must never be followed by a lock indication
    a_no_lock_after_sync_loss : assert property (@(posedge i_clock) disable iff (i_reset)
        $past(i_enable && !i_block_lock) |-> !o_am_lock);

    a_accept_resync_exclusive : assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_marker_accept && o_resync));

endmodule

`default_nettype wire

// File: source/am_lock_lane.sv
/*
 * alignment marker lock lane
 * marker search and lock, bip check, marker replacement and resync count
 */
`default_nettype none

`include "am_lock_defines.svh"

module am_lock_lane
    import am_lock_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_enable,
    input  logic        i_valid,
    input  logic        i_block_lock,       // from block sync
    input  block_t      i_data,
    input  am_t         i_compare_mask,
    input  period_t     i_am_period,
    input  thr_t        i_valid_thr,
    input  thr_t        i_invalid_thr,
    output block_t      o_data,
    output logic        o_valid,
    output logic        o_start_of_lane,    // to deskew
    output logic        o_am_lock,
    output lane_id_t    o_lane_id,
    output err_cnt_t    o_error_count,
    output resync_cnt_t o_resync_count
);

    localparam block_t ctrl_block = {`AM_SH_CTRL, `AM_CTRL_REPLACE};

    am_t         am_value;
    bip_t        received_bip;
    bip_t        calculated_bip;
    logic        am_match;
    lane_id_t    match_lane;
    lane_id_t    locked_lane;
    logic        restrict_lane;
    logic        lock_next;
    logic        marker_accept;
    logic        resync;
    logic        replace;
    block_t      data_q;
    logic        valid_q;
    logic        sol_q;
    logic        lock_q;
    lane_id_t    lane_id_q;
    resync_cnt_t resync_cnt;

    assign am_value     = {i_data[`AM_HI_MSB -: `AM_NB_AM/2], i_data[`AM_LO_MSB -: `AM_NB_AM/2]};
    assign received_bip = i_data[`AM_BIP_MSB -: `AM_NB_BIP];
    assign replace      = marker_accept && lock_next;  // locked or lock reached now

    am_comparator u_am_comparator
    (
        .i_am_value      (am_value),
        .i_compare_mask  (i_compare_mask),
        .i_restrict      (restrict_lane),
        .i_locked_lane   (locked_lane),
        .o_am_match      (am_match),
        .o_match_lane    (match_lane)
    );

    am_lock_fsm u_am_lock_fsm
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_enable        (i_enable),
        .i_valid         (i_valid),
        .i_block_lock    (i_block_lock),
        .i_am_match      (am_match),
        .i_match_lane    (match_lane),
        .i_am_period     (i_am_period),
        .i_valid_thr     (i_valid_thr),
        .i_invalid_thr   (i_invalid_thr),
        .o_restrict      (restrict_lane),
        .o_locked_lane   (locked_lane),
        .o_am_lock       (lock_next),
        .o_marker_accept (marker_accept),
        .o_resync        (resync)
    );

    bip_calculator u_bip_calculator
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_enable        (i_enable),
        .i_valid         (i_valid),
        .i_data          (i_data),
        .i_restart       (marker_accept || resync),
        .o_bip           (calculated_bip)
    );

    bip_error_counter u_bip_error_counter
    (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_enable         (i_enable),
        .i_check          (marker_accept && lock_q),   // already locked before this marker
        .i_clear          (resync),
        .i_received_bip   (received_bip),
        .i_calculated_bip (calculated_bip),
        .o_error_count    (o_error_count)
    );

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
            data_q <= replace ? ctrl_block : i_data;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid_q    <= 1'b0;
            sol_q      <= 1'b0;
            lock_q     <= 1'b0;
            lane_id_q  <= '0;
            resync_cnt <= '0;
        end
        else
        begin
            valid_q <= i_enable && i_valid;
            sol_q   <= replace;
            lock_q  <= lock_next;
            if (lock_next)
                lane_id_q <= locked_lane;
            if (resync)
                resync_cnt <= resync_cnt + 1'b1;
        end
    end

    assign o_data          = data_q;
    assign o_valid         = valid_q;
    assign o_start_of_lane = sol_q;
    assign o_am_lock       = lock_q;
    assign o_lane_id       = lane_id_q;
    assign o_resync_count  = resync_cnt;

endmodule

`default_nettype wire

// File: source/am_lock_pkg.sv
/*
 * alignment marker lock types
 * vector typedefs and the lock state encoding
 */
`default_nettype none

`include "am_lock_defines.svh"

package am_lock_pkg;

    // coded block with sync header
    typedef logic [`AM_NB_BLOCK-1:0]       block_t;

    typedef logic [`AM_NB_AM-1:0]          am_t;        // marker pattern
    typedef logic [`AM_NB_BIP-1:0]         bip_t;
    typedef logic [`AM_NB_LANE_ID-1:0]     lane_id_t;

    // blocks between two markers
    typedef logic [`AM_NB_PERIOD-1:0]      period_t;

    typedef logic [`AM_NB_THR-1:0]         thr_t;       // valid and invalid thresholds
    typedef logic [`AM_NB_ERR_CNT-1:0]     err_cnt_t;
    typedef logic [`AM_NB_RESYNC_CNT-1:0]  resync_cnt_t;

    typedef enum logic [1:0]
    {
        lock_search,
        lock_confirm,
        lock_locked
    } lock_state_t;

endpackage

`default_nettype wire

// File: source/bip_calculator.sv
/*
 * bit interleaved parity calculator
 * running bip8 over the payload of the blocks between two markers
 */
`default_nettype none

`include "am_lock_defines.svh"

module bip_calculator
    import am_lock_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_enable,
    input  logic        i_valid,
    input  block_t      i_data,
    input  logic        i_restart,
    output bip_t        o_bip
);

    bip_t bip;
    bip_t block_bip;

    // payload bit i folds into parity bit i mod 8, sync header excluded
    always_comb
    begin
        block_bip = '0;
        for (int i = 0; i < `AM_NB_BLOCK - 2; i++)
        begin
            block_bip[i % `AM_NB_BIP] = block_bip[i % `AM_NB_BIP] ^ i_data[i];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            bip <= '0;
        else if (i_enable)
        begin
            if (i_restart)
                bip <= '0;                  // marker block does not enter
            else if (i_valid)
                bip <= bip ^ block_bip;
        end
    end

    assign o_bip = bip;

endmodule

`default_nettype wire

// File: source/bip_error_counter.sv
/*
 * bip error counter
 * saturating count of parity mismatches on checked markers
 */
`default_nettype none

module bip_error_counter
    import am_lock_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_enable,
    input  logic        i_check,            // locked marker accepted
    input  logic        i_clear,
    input  bip_t        i_received_bip,
    input  bip_t        i_calculated_bip,
    output err_cnt_t    o_error_count
);

    localparam err_cnt_t count_max = '1;

    err_cnt_t count;
    logic     mismatch;

    assign mismatch = i_check && (i_received_bip != i_calculated_bip);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            count <= '0;
        else if (i_enable)
        begin
            if (i_clear)
                count <= '0;
            else if (mismatch && (count != count_max))
                count <= count + 1'b1;      // hold at max
        end
    end

    assign o_error_count = count;

    a_no_wrap : assert property (@(posedge i_clock) disable iff (i_reset)
        (!$past(i_reset) && ($past(o_error_count) != '0) && (o_error_count == '0))
            |-> $past(i_enable && i_clear));

endmodule

`default_nettype wire
